//--- hdl/dac_channel_mux.sv
// DAC channel source selector
// Pattern alternator and registered source mux with DMA enable flag

`timescale 1ns/1ps

module dac_channel_mux (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   sync_pulse,
  input  logic                   fmt_offset,
  input  dac_tpl_pkg::data_sel_t data_sel,
  input  dac_tpl_pkg::cfg_word_t pat0,
  input  dac_tpl_pkg::cfg_word_t pat1,
  input  dac_tpl_pkg::sample_t   tone_data,
  input  dac_tpl_pkg::sample_t   pn7_data,
  input  dac_tpl_pkg::sample_t   pn15_data,
  input  dac_tpl_pkg::sample_t   dma_data,
  output dac_tpl_pkg::sample_t   dac_data,
  output logic                   dac_enable
);

  import dac_tpl_pkg::*;

  logic    pat_sel;
  sample_t pat_data;
  sample_t dds_data;

  // ******************************
  // Pattern alternator
  // ******************************

  // Toggles every clock, sync forces the next word back to pat0
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pat_sel <= 1'b0;
    end else if (sync_pulse) begin
      pat_sel <= 1'b0;
    end else begin
      pat_sel <= ~pat_sel;
    end
  end

  assign pat_data = pat_sel ? pat1 : pat0;

  // Offset binary is two's complement with the sign bit flipped
  assign dds_data = {tone_data[15] ^ fmt_offset, tone_data[14:0]};

  // ******************************
  // Source select
  // ******************************

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      dac_data   <= '0;
      dac_enable <= 1'b0;
    end else begin
      // Enable only while the DMA stream is the source
      dac_enable <= (data_sel == SEL_DMA);
      case (data_sel)
        SEL_PN15:  dac_data <= pn15_data;
        SEL_PN7:   dac_data <= pn7_data;
        SEL_NPN15: dac_data <= ~pn15_data;
        SEL_NPN7:  dac_data <= ~pn7_data;
        SEL_ZERO:  dac_data <= '0;
        SEL_DMA:   dac_data <= dma_data;
        SEL_PAT:   dac_data <= pat_data;
        // SEL_DDS and any unused code
        default:   dac_data <= dds_data;
      endcase
    end
  end

endmodule

//--- hdl/dac_pn_gen.sv
// PN7 and PN15 test sequence generator
// Two LFSRs, each advancing 16 bits per clock

`timescale 1ns/1ps

module dac_pn_gen (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 sync_pulse,
  output dac_tpl_pkg::sample_t pn7_data,
  output dac_tpl_pkg::sample_t pn15_data
);

  import dac_tpl_pkg::*;

  logic [6:0]  pn7_state;
  logic [14:0] pn15_state;
  logic [6:0]  pn7_next;
  logic [14:0] pn15_next;
  sample_t     pn7_word;
  sample_t     pn15_word;

  // ******************************
  // Unrolled LFSR steps
  // ******************************

  // x^7 + x^6 + 1, feedback bit is also the output bit
  always_comb begin
    logic [6:0] s;
    logic       fb;
    s = pn7_state;
    for (int i = 0; i < 16; i++) begin
      fb = s[6] ^ s[5];
      // First generated bit goes to the MSB
      pn7_word[15-i] = fb;
      s = {s[5:0], fb};
    end
    pn7_next = s;
  end

  // x^15 + x^14 + 1, same structure
  always_comb begin
    logic [14:0] s;
    logic        fb;
    s = pn15_state;
    for (int i = 0; i < 16; i++) begin
      fb = s[14] ^ s[13];
      pn15_word[15-i] = fb;
      s = {s[13:0], fb};
    end
    pn15_next = s;
  end

  // ******************************
  // State and output registers
  // ******************************

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pn7_state  <= PN_SEED[6:0];
      pn15_state <= PN_SEED;
      pn7_data   <= '0;
      pn15_data  <= '0;
    end else begin
      // Sync restarts both sequences from the seed
      if (sync_pulse) begin
        pn7_state  <= PN_SEED[6:0];
        pn15_state <= PN_SEED;
      end else begin
        pn7_state  <= pn7_next;
        pn15_state <= pn15_next;
      end
      pn7_data  <= pn7_word;
      pn15_data <= pn15_word;
    end
  end

endmodule

//--- hdl/dac_regmap.sv
// DAC transport layer register block
// Wishbone classic slave holding the channel configuration and the sync pulse

`timescale 1ns/1ps

module dac_regmap (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   wb_cyc,
  input  logic                   wb_stb,
  input  logic                   wb_we,
  input  dac_tpl_pkg::wb_addr_t  wb_adr,
  input  logic [31:0]            wb_dat_i,
  output logic [31:0]            wb_dat_o,
  output logic                   wb_ack,
  output dac_tpl_pkg::data_sel_t data_sel,
  output logic                   fmt_offset,
  output logic                   sync_pulse,
  output dac_tpl_pkg::cfg_word_t pat0,
  output dac_tpl_pkg::cfg_word_t pat1,
  output dac_tpl_pkg::cfg_word_t scale0,
  output dac_tpl_pkg::cfg_word_t init0,
  output dac_tpl_pkg::cfg_word_t incr0,
  output dac_tpl_pkg::cfg_word_t scale1,
  output dac_tpl_pkg::cfg_word_t init1,
  output dac_tpl_pkg::cfg_word_t incr1
);

  import dac_tpl_pkg::*;

  wb_state_t   state;
  logic        req;
  logic [31:0] rd_data;

  // New request only counts while idle
  assign req = wb_cyc && wb_stb && (state == IDLE);

  // ******************************
  // Bus FSM and register writes
  // ******************************

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= IDLE;
      wb_ack     <= 1'b0;
      sync_pulse <= 1'b0;
      data_sel   <= SEL_DDS;
      fmt_offset <= 1'b0;
      pat0       <= '0;
      pat1       <= '0;
      scale0     <= '0;
      init0      <= '0;
      incr0      <= '0;
      scale1     <= '0;
      init1      <= '0;
      incr1      <= '0;
    end else begin
      // Sync is a single-cycle strobe
      sync_pulse <= 1'b0;
      case (state)
        IDLE: begin
          if (req) begin
            state  <= ACK;
            wb_ack <= 1'b1;
            if (wb_we) begin
              // Write lands on the ack edge
              case (wb_adr)
                REG_CTRL: begin
                  data_sel   <= wb_dat_i[3:0];
                  fmt_offset <= wb_dat_i[4];
                  sync_pulse <= wb_dat_i[8];
                end
                REG_PAT0:   pat0   <= wb_dat_i[15:0];
                REG_PAT1:   pat1   <= wb_dat_i[15:0];
                REG_SCALE0: scale0 <= wb_dat_i[15:0];
                REG_INIT0:  init0  <= wb_dat_i[15:0];
                REG_INCR0:  incr0  <= wb_dat_i[15:0];
                REG_SCALE1: scale1 <= wb_dat_i[15:0];
                REG_INIT1:  init1  <= wb_dat_i[15:0];
                REG_INCR1:  incr1  <= wb_dat_i[15:0];
                // Unused addresses drop the write
                default: ;
              endcase
            end
          end
        end
        // One idle clock after every ack
        ACK: begin
          state  <= IDLE;
          wb_ack <= 1'b0;
        end
      endcase
    end
  end

  // ******************************
  // Read path
  // ******************************

  // Sync bit is never stored, so it reads zero
  always_comb begin
    case (wb_adr)
      REG_CTRL:   rd_data = {27'd0, fmt_offset, data_sel};
      REG_PAT0:   rd_data = {16'd0, pat0};
      REG_PAT1:   rd_data = {16'd0, pat1};
      REG_SCALE0: rd_data = {16'd0, scale0};
      REG_INIT0:  rd_data = {16'd0, init0};
      REG_INCR0:  rd_data = {16'd0, incr0};
      REG_SCALE1: rd_data = {16'd0, scale1};
      REG_INIT1:  rd_data = {16'd0, init1};
      REG_INCR1:  rd_data = {16'd0, incr1};
      default:    rd_data = '0;
    endcase
  end

  // Captured with the ack, valid while ack is high
  always_ff @(posedge clk) begin
    if (req) begin
      wb_dat_o <= rd_data;
    end
  end

endmodule

//--- hdl/dac_tone_gen.sv
// Two-tone DDS with triangle waves
// Phase accumulators, triangle folding, scaling and summation

`timescale 1ns/1ps

module dac_tone_gen #(
  parameter int PHASE_W = 16
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   sync_pulse,
  input  dac_tpl_pkg::cfg_word_t scale0,
  input  dac_tpl_pkg::cfg_word_t init0,
  input  dac_tpl_pkg::cfg_word_t incr0,
  input  dac_tpl_pkg::cfg_word_t scale1,
  input  dac_tpl_pkg::cfg_word_t init1,
  input  dac_tpl_pkg::cfg_word_t incr1,
  output dac_tpl_pkg::sample_t   tone_data
);

  import dac_tpl_pkg::*;

  // Low fractional bits below the 16-bit register fields
  localparam int PAD = PHASE_W - 16;

  logic [PHASE_W-1:0] acc0;
  logic [PHASE_W-1:0] acc1;
  cfg_word_t          phase0;
  cfg_word_t          phase1;
  logic [14:0]        fold0;
  logic [14:0]        fold1;
  logic signed [15:0] wave0;
  logic signed [15:0] wave1;
  logic signed [31:0] prod0;
  logic signed [31:0] prod1;
  logic signed [15:0] half0;
  logic signed [15:0] half1;

  // ******************************
  // Phase accumulators
  // ******************************

  // Fields are left-aligned, extra bits start at zero
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      acc0 <= '0;
      acc1 <= '0;
    end else if (sync_pulse) begin
      acc0 <= PHASE_W'(init0) << PAD;
      acc1 <= PHASE_W'(init1) << PAD;
    end else begin
      acc0 <= acc0 + (PHASE_W'(incr0) << PAD);
      acc1 <= acc1 + (PHASE_W'(incr1) << PAD);
    end
  end

  // ******************************
  // Triangle shaping
  // ******************************

  assign phase0 = acc0[PHASE_W-1 -: 16];
  assign phase1 = acc1[PHASE_W-1 -: 16];

  // Second half of the period runs the ramp back down
  assign fold0 = phase0[15] ? ~phase0[14:0] : phase0[14:0];
  assign fold1 = phase1[15] ? ~phase1[14:0] : phase1[14:0];

  // Ramp 0..65534 shifted to a signed swing around zero
  assign wave0 = $signed({fold0, 1'b0} - 16'h8000);
  assign wave1 = $signed({fold1, 1'b0} - 16'h8000);

  // Scale acts as an unsigned fraction of full range
  assign prod0 = wave0 * $signed({1'b0, scale0});
  assign prod1 = wave1 * $signed({1'b0, scale1});

  // Halve each tone so the sum cannot overflow
  assign half0 = $signed(prod0[31:16]) >>> 1;
  assign half1 = $signed(prod1[31:16]) >>> 1;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tone_data <= '0;
    end else begin
      tone_data <= sample_t'(half0 + half1);
    end
  end

endmodule

//--- hdl/dac_tpl_pkg.sv
// DAC transport layer shared definitions
// Sample and register types, register map, data-select codes, PN seed

package dac_tpl_pkg;

  // ******************************
  // Types
  // ******************************

  // One DAC sample, two's complement or offset binary
  typedef logic [15:0] sample_t;

  // Register field such as scale, initial phase or increment
  typedef logic [15:0] cfg_word_t;

  // Channel source select code
  typedef logic [3:0] data_sel_t;

  // Wishbone word address
  typedef logic [3:0] wb_addr_t;

  // Bus handshake states of the register block
  typedef enum logic {
    IDLE,
    ACK
  } wb_state_t;

  // ******************************
  // Data-select codes
  // ******************************

  // Anything not listed falls back to the DDS
  localparam data_sel_t SEL_DDS   = 4'd0;
  localparam data_sel_t SEL_PAT   = 4'd1;
  localparam data_sel_t SEL_DMA   = 4'd2;
  localparam data_sel_t SEL_ZERO  = 4'd3;
  localparam data_sel_t SEL_NPN7  = 4'd4;
  localparam data_sel_t SEL_NPN15 = 4'd5;
  localparam data_sel_t SEL_PN7   = 4'd6;
  localparam data_sel_t SEL_PN15  = 4'd7;

  // ******************************
  // Register addresses
  // ******************************

  localparam wb_addr_t REG_CTRL   = 4'd0;
  localparam wb_addr_t REG_PAT0   = 4'd1;
  localparam wb_addr_t REG_PAT1   = 4'd2;
  localparam wb_addr_t REG_SCALE0 = 4'd3;
  localparam wb_addr_t REG_INIT0  = 4'd4;
  localparam wb_addr_t REG_INCR0  = 4'd5;
  localparam wb_addr_t REG_SCALE1 = 4'd6;
  localparam wb_addr_t REG_INIT1  = 4'd7;
  localparam wb_addr_t REG_INCR1  = 4'd8;

  // Restart value of both LFSRs, PN7 uses the low 7 bits
  localparam logic [14:0] PN_SEED = '1;

endpackage

//--- hdl/dac_tpl_top.sv
// DAC transport layer single-lane data source
// Register block, tone and PN generators, channel selector

`timescale 1ns/1ps

module dac_tpl_top #(
  parameter int PHASE_W = 16
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  wb_cyc,
  input  logic                  wb_stb,
  input  logic                  wb_we,
  input  dac_tpl_pkg::wb_addr_t wb_adr,
  input  logic [31:0]           wb_dat_i,
  output logic [31:0]           wb_dat_o,
  output logic                  wb_ack,
  input  dac_tpl_pkg::sample_t  dma_data,
  output dac_tpl_pkg::sample_t  dac_data,
  output logic                  dac_enable
);

  import dac_tpl_pkg::*;

  // ******************************
  // Configuration wires
  // ******************************

  data_sel_t data_sel;
  logic      fmt_offset;
  logic      sync_pulse;
  cfg_word_t pat0;
  cfg_word_t pat1;
  cfg_word_t scale0;
  cfg_word_t init0;
  cfg_word_t incr0;
  cfg_word_t scale1;
  cfg_word_t init1;
  cfg_word_t incr1;

  // Generator outputs into the selector
  sample_t tone_data;
  sample_t pn7_data;
  sample_t pn15_data;

  dac_regmap u_regmap (
    .clk        (clk),
    .rst_n      (rst_n),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_adr     (wb_adr),
    .wb_dat_i   (wb_dat_i),
    .wb_dat_o   (wb_dat_o),
    .wb_ack     (wb_ack),
    .data_sel   (data_sel),
    .fmt_offset (fmt_offset),
    .sync_pulse (sync_pulse),
    .pat0       (pat0),
    .pat1       (pat1),
    .scale0     (scale0),
    .init0      (init0),
    .incr0      (incr0),
    .scale1     (scale1),
    .init1      (init1),
    .incr1      (incr1)
  );

  dac_tone_gen #(
    .PHASE_W (PHASE_W)
  ) u_tone_gen (
    .clk        (clk),
    .rst_n      (rst_n),
    .sync_pulse (sync_pulse),
    .scale0     (scale0),
    .init0      (init0),
    .incr0      (incr0),
    .scale1     (scale1),
    .init1      (init1),
    .incr1      (incr1),
    .tone_data  (tone_data)
  );

  dac_pn_gen u_pn_gen (
    .clk        (clk),
    .rst_n      (rst_n),
    .sync_pulse (sync_pulse),
    .pn7_data   (pn7_data),
    .pn15_data  (pn15_data)
  );

  // Sync reaches all three blocks on the same edge
  dac_channel_mux u_channel_mux (
    .clk        (clk),
    .rst_n      (rst_n),
    .sync_pulse (sync_pulse),
    .fmt_offset (fmt_offset),
    .data_sel   (data_sel),
    .pat0       (pat0),
    .pat1       (pat1),
    .tone_data  (tone_data),
    .pn7_data   (pn7_data),
    .pn15_data  (pn15_data),
    .dma_data   (dma_data),
    .dac_data   (dac_data),
    .dac_enable (dac_enable)
  );

endmodule

//--- project.f
hdl/dac_tpl_pkg.sv
hdl/dac_regmap.sv
hdl/dac_tone_gen.sv
hdl/dac_pn_gen.sv
hdl/dac_channel_mux.sv
hdl/dac_tpl_top.sv
verification/dac_tpl_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and judge the result from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal -f project.f --top-module dac_tpl_tb \
  --Mdir obj_dir -o dac_tpl_sim > build.log 2>&1 \
  && ./obj_dir/dac_tpl_sim > sim.log 2>&1 \
  || { echo "Build or simulation did not complete"; cat build.log sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -qF '** FAIL **' sim.log && { echo "Simulation reported failure"; exit 1; }
grep -qF '** PASS **' sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"

//--- verification/dac_tpl_tb.sv
// DAC transport layer testbench
// Table-driven checks of register access, pattern, DMA, PN and two-tone DDS output

`timescale 1ns/1ps

module dac_tpl_tb;

  import dac_tpl_pkg::*;

  localparam int PHASE_W   = 20;
  localparam int NUM_TESTS = 10;
  localparam int RESET_CYC = 8;
  localparam int BUS_CYC   = 4;
  localparam int ACK_WAIT  = 16;
  // Register phase accesses, 8 w + 8 r + ctrl w/r + 14 unused + 9 re-reads
  localparam int RB_ACCESS = 41;

  // One table entry, registers then select, format, sync and sample count
  typedef struct packed {
    cfg_word_t  pat0;
    cfg_word_t  pat1;
    cfg_word_t  scale0;
    cfg_word_t  init0;
    cfg_word_t  incr0;
    cfg_word_t  scale1;
    cfg_word_t  init1;
    cfg_word_t  incr1;
    data_sel_t  sel;
    logic       fmt;
    logic       sync;
    logic [7:0] count;
  } vec_t;

  logic        clk;
  logic        rst_n;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  wb_addr_t    wb_adr;
  logic [31:0] wb_dat_i;
  logic [31:0] wb_dat_o;
  logic        wb_ack;
  sample_t     dma_data;
  sample_t     dac_data;
  logic        dac_enable;

  vec_t  tbl [NUM_TESTS];
  string names [NUM_TESTS];
  int    seed = 38512;
  int    errors = 0;
  int    checks = 0;
  int    tests_run = 0;
  int    tests_failed = 0;
  int    cycles = 0;
  int    cycle_limit = 1000000;

  dac_tpl_top #(
    .PHASE_W (PHASE_W)
  ) uut (
    .clk        (clk),
    .rst_n      (rst_n),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_adr     (wb_adr),
    .wb_dat_i   (wb_dat_i),
    .wb_dat_o   (wb_dat_o),
    .wb_ack     (wb_ack),
    .dma_data   (dma_data),
    .dac_data   (dac_data),
    .dac_enable (dac_enable)
  );

  // 20 ns clock
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Run limit in cycles
  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("Timeout after %0d cycles, the test sequence did not complete", cycles);
      $display("** FAIL **");
      $finish;
    end
  end

  // ******************************
  // Reference models
  // ******************************

  // One halved triangle tone at sample k after sync
  function automatic int tone_half(cfg_word_t init, cfg_word_t incr, cfg_word_t scale, int k);
    logic [15:0] ph;
    int          ramp;
    int          wave;
    int          top;
    ph = 16'(init + k * incr);
    // Rising ramp in the first half period, falling in the second
    ramp = (ph < 16'h8000) ? int'(ph) : 65535 - int'(ph);
    wave = 2 * ramp - 32768;
    top  = (wave * int'(scale)) >>> 16;
    // Signed top product word, halved with its sign kept
    return top >>> 1;
  endfunction

  function automatic logic [15:0] dds_model(vec_t v, int k);
    logic [15:0] sum;
    sum = 16'(tone_half(v.init0, v.incr0, v.scale0, k) + tone_half(v.init1, v.incr1, v.scale1, k));
    // Offset binary flips the sign bit
    if (v.fmt) begin
      sum[15] = ~sum[15];
    end
    return sum;
  endfunction

  // Word k of the PN sequence of the given order, seed all ones
  function automatic logic [15:0] pn_model(int order, int k);
    logic        bits [0:1023];
    logic [15:0] w;
    for (int i = 0; i < order; i++) begin
      bits[i] = 1'b1;
    end
    // b[n] = b[n-order] ^ b[n-order+1] for taps x^order + x^(order-1) + 1
    for (int m = 0; m < 16 * (k + 1); m++) begin
      bits[order + m] = bits[m] ^ bits[m + 1];
    end
    for (int b = 0; b < 16; b++) begin
      w[15 - b] = bits[order + 16 * k + b];
    end
    return w;
  endfunction

  function automatic logic [15:0] expected_sample(vec_t v, int k, logic [15:0] dma_val);
    case (v.sel)
      SEL_PAT:   return (k % 2 == 0) ? v.pat0 : v.pat1;
      SEL_DMA:   return dma_val;
      SEL_ZERO:  return 16'h0000;
      SEL_NPN7:  return ~pn_model(7, k);
      SEL_NPN15: return ~pn_model(15, k);
      SEL_PN7:   return pn_model(7, k);
      SEL_PN15:  return pn_model(15, k);
      default:   return dds_model(v, k);
    endcase
  endfunction

  function automatic logic [15:0] reg_value(int a);
    return 16'(a * 16'h1111 + 16'h0102);
  endfunction

  // ******************************
  // Check and bus tasks
  // ******************************

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic report_result(input string name, input int start_err);
    tests_run++;
    if (errors == start_err) begin
      $display("%-16s ok", name);
    end else begin
      tests_failed++;
      $display("%-16s failed with %0d errors", name, errors - start_err);
    end
  endtask

  // Classic cycle, exactly one ack expected
  task automatic bus_cycle(input logic write, input wb_addr_t addr, input logic [31:0] wdata,
                           output logic [31:0] rdata);
    int waited;
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= write;
    wb_adr   <= addr;
    wb_dat_i <= wdata;
    waited = 0;
    @(negedge clk);
    while (!wb_ack && waited < ACK_WAIT) begin
      @(negedge clk);
      waited++;
    end
    if (!wb_ack) begin
      $display("Bus access to address %0d was never acknowledged", addr);
      errors++;
    end
    rdata = wb_dat_o;
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
    @(negedge clk);
    if (wb_ack) begin
      $display("Bus access to address %0d held ack for more than one cycle", addr);
      errors++;
    end
  endtask

  task automatic bus_write(input wb_addr_t addr, input logic [31:0] wdata);
    logic [31:0] unused_rd;
    bus_cycle(1'b1, addr, wdata, unused_rd);
  endtask

  task automatic bus_read(input wb_addr_t addr, output logic [31:0] rdata);
    bus_cycle(1'b0, addr, 32'h0, rdata);
  endtask

  // ******************************
  // Test sequences
  // ******************************

  task automatic fill_table;
    names[0] = "pattern";
    tbl[0] = '{16'hA5A5, 16'h5A5A, 16'h0000, 16'h0000, 16'h0000,
               16'h0000, 16'h0000, 16'h0000, SEL_PAT, 1'b0, 1'b1, 8'd16};
    names[1] = "dma_stream";
    tbl[1] = '{16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000,
               16'h0000, 16'h0000, 16'h0000, SEL_DMA, 1'b0, 1'b0, 8'd20};
    names[2] = "zero";
    tbl[2] = '{16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000,
               16'h0000, 16'h0000, 16'h0000, SEL_ZERO, 1'b0, 1'b0, 8'd8};
    names[3] = "pn7";
    tbl[3] = '{16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000,
               16'h0000, 16'h0000, 16'h0000, SEL_PN7, 1'b0, 1'b1, 8'd24};
    names[4] = "pn15";
    tbl[4] = '{16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000,
               16'h0000, 16'h0000, 16'h0000, SEL_PN15, 1'b0, 1'b1, 8'd24};
    names[5] = "pn7_inverted";
    tbl[5] = '{16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000,
               16'h0000, 16'h0000, 16'h0000, SEL_NPN7, 1'b0, 1'b1, 8'd12};
    names[6] = "pn15_inverted";
    tbl[6] = '{16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000,
               16'h0000, 16'h0000, 16'h0000, SEL_NPN15, 1'b0, 1'b1, 8'd12};
    names[7] = "dds_twos";
    tbl[7] = '{16'h0000, 16'h0000, 16'h8000, 16'h0000, 16'h0400,
               16'h4000, 16'h4000, 16'h0C00, SEL_DDS, 1'b0, 1'b1, 8'd32};
    names[8] = "dds_offset";
    tbl[8] = '{16'h0000, 16'h0000, 16'hFFFF, 16'h2000, 16'h0900,
               16'h7FFF, 16'hC000, 16'h1100, SEL_DDS, 1'b1, 1'b1, 8'd32};
    // Unused code 11 falls back to the DDS
    names[9] = "dds_unused_sel";
    tbl[9] = '{16'h0000, 16'h0000, 16'h6000, 16'h1000, 16'h0300,
               16'h3000, 16'h8000, 16'h0700, 4'hB, 1'b0, 1'b1, 8'd16};
  endtask

  task automatic reg_readback;
    logic [31:0] rd;
    int          start_err;
    start_err = errors;
    // Upper data bits are not stored
    for (int a = 1; a <= 8; a++) begin
      bus_write(wb_addr_t'(a), 32'hC0DE_0000 | reg_value(a));
    end
    for (int a = 1; a <= 8; a++) begin
      bus_read(wb_addr_t'(a), rd);
      check($sformatf("reg_readback[%0d]", a), {16'h0, reg_value(a)}, rd);
    end
    // Select 7, offset format, sync set
    bus_write(REG_CTRL, 32'h0000_0117);
    bus_read(REG_CTRL, rd);
    check("reg_readback[ctrl]", 32'h0000_0017, rd);
    report_result("reg_readback", start_err);
  endtask

  task automatic unused_addr;
    logic [31:0] rd;
    int          start_err;
    start_err = errors;
    for (int a = 9; a <= 15; a++) begin
      bus_write(wb_addr_t'(a), 32'hFFFF_FFFF);
    end
    for (int a = 9; a <= 15; a++) begin
      bus_read(wb_addr_t'(a), rd);
      check($sformatf("unused_addr[%0d]", a), 32'h0, rd);
    end
    // Nothing else moved
    for (int a = 1; a <= 8; a++) begin
      bus_read(wb_addr_t'(a), rd);
      check($sformatf("unused_addr_keep[%0d]", a), {16'h0, reg_value(a)}, rd);
    end
    bus_read(REG_CTRL, rd);
    check("unused_addr_keep[ctrl]", 32'h0000_0017, rd);
    report_result("unused_addr", start_err);
  endtask

  task automatic run_test(input int t);
    vec_t        v;
    int          lat;
    int          start_err;
    logic [15:0] exp;
    logic [15:0] dma_prev;
    logic [15:0] dma_next;
    v = tbl[t];
    start_err = errors;
    bus_write(REG_PAT0, {16'h0, v.pat0});
    bus_write(REG_PAT1, {16'h0, v.pat1});
    bus_write(REG_SCALE0, {16'h0, v.scale0});
    bus_write(REG_INIT0, {16'h0, v.init0});
    bus_write(REG_INCR0, {16'h0, v.incr0});
    bus_write(REG_SCALE1, {16'h0, v.scale1});
    bus_write(REG_INIT1, {16'h0, v.init1});
    bus_write(REG_INCR1, {16'h0, v.incr1});
    bus_write(REG_CTRL, {23'd0, v.sync, 3'd0, v.fmt, v.sel});
    // Pattern, DMA and zero lead the generators by one clock
    lat = (v.sel inside {SEL_PAT, SEL_DMA, SEL_ZERO}) ? 1 : 2;
    dma_prev = dma_data;
    for (int j = 1; j < lat + int'(v.count); j++) begin
      dma_next = 16'($random(seed));
      @(posedge clk);
      dma_data <= dma_next;
      @(negedge clk);
      if (j >= lat) begin
        exp = expected_sample(v, j - lat, dma_prev);
        check($sformatf("%s[%0d]", names[t], j - lat), {16'h0, exp}, {16'h0, dac_data});
        check($sformatf("%s_enable[%0d]", names[t], j - lat), v.sel == SEL_DMA, dac_enable);
      end
      dma_prev = dma_next;
    end
    report_result(names[t], start_err);
  endtask

  // ******************************
  // Main sequence
  // ******************************

  initial begin
    int total;
    int start_err;
    rst_n    = 1'b0;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_i = '0;
    dma_data = '0;
    fill_table();
    total = 0;
    for (int t = 0; t < NUM_TESTS; t++) begin
      total += int'(tbl[t].count);
    end
    cycle_limit = 2 * (RESET_CYC + total + NUM_TESTS * 2 + (RB_ACCESS + NUM_TESTS * 9) * BUS_CYC);
    repeat (RESET_CYC) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    start_err = errors;
    check("reset_dac_data", 32'h0, {16'h0, dac_data});
    check("reset_dac_enable", 32'h0, dac_enable);
    check("reset_wb_ack", 32'h0, wb_ack);
    check("reset_sync", 32'h0, uut.sync_pulse);
    report_result("reset_state", start_err);
    reg_readback();
    unused_addr();
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_test(t);
    end
    $display("Tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule
